/* tb.f */
rtl/mips_pkg.sv
rtl/mips_regfile.sv
rtl/mips_execute.sv
rtl/mips_control.sv
rtl/mips_cpu_bus.sv
tests/clock_gen.sv
tests/avalon_mem.sv
tests/mips_cpu_bus_tb.sv

/* Makefile */
# Verilator build and run for the MIPS CPU testbench

VERILATOR ?= verilator
TOP       ?= mips_cpu_bus_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(BUILD_DIR)

/* tests/mips_cpu_bus_tb.sv */
/*
 * MIPS CPU testbench
 * Runs small programs through the core and checks results and Avalon protocol
 */
module mips_cpu_bus_tb;

    logic        clk, reset, waitrequest, read, write, active;
    logic [31:0] address, writedata, readdata, register_v0;
    logic [3:0]  byteenable;
    logic        wait_en, check_fetch, reset_q, stalled;
    logic [31:0] lfsr, fetch_addr, store_addr, store_data, mem_val;
    logic [31:0] prev_addr, prev_wdata;
    logic        prev_read, prev_write;
    logic [31:0] opa [17];
    logic [31:0] opb [17];
    logic [31:0] prog [$];
    int          value_errors, protocol_errors, cycles, budget, store_count;
    string       test_name;
    string       alu_names [17] = '{"addu", "subu", "and", "or", "xor", "slt", "sltu",
        "sll", "srl", "sra", "addiu", "slti", "sltiu", "andi", "ori", "xori", "lui"};

    clock_gen #(.PERIOD(4)) clk_src (.clk(clk));

    avalon_mem mem_model (
        .clk(clk), .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata)
    );

    mips_cpu_bus uut (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_bit();
        logic b;
        b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], b};
        return b;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            w[i] = next_bit();
        end
        return w;
    endfunction

    function automatic logic [31:0] r_ins(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd, logic [4:0] sh);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_ins(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic load_word(input logic [4:0] r, input logic [31:0] value);
        prog.push_back(i_ins(mips_pkg::OP_LUI, 0, r, value[31:16]));
        prog.push_back(i_ins(mips_pkg::OP_ORI, r, r, value[15:0]));
    endtask

    // Operands in r8 and r9, result in v0
    function automatic logic [31:0] alu_instr(int k, logic [31:0] b);
        case (k)
            0:  return r_ins(mips_pkg::FN_ADDU, 8, 9, 2, 0);
            1:  return r_ins(mips_pkg::FN_SUBU, 8, 9, 2, 0);
            2:  return r_ins(mips_pkg::FN_AND, 8, 9, 2, 0);
            3:  return r_ins(mips_pkg::FN_OR, 8, 9, 2, 0);
            4:  return r_ins(mips_pkg::FN_XOR, 8, 9, 2, 0);
            5:  return r_ins(mips_pkg::FN_SLT, 8, 9, 2, 0);
            6:  return r_ins(mips_pkg::FN_SLTU, 8, 9, 2, 0);
            7:  return r_ins(mips_pkg::FN_SLL, 0, 9, 2, b[4:0]);
            8:  return r_ins(mips_pkg::FN_SRL, 0, 9, 2, b[4:0]);
            9:  return r_ins(mips_pkg::FN_SRA, 0, 9, 2, b[4:0]);
            10: return i_ins(mips_pkg::OP_ADDIU, 8, 2, b[15:0]);
            11: return i_ins(mips_pkg::OP_SLTI, 8, 2, b[15:0]);
            12: return i_ins(mips_pkg::OP_SLTIU, 8, 2, b[15:0]);
            13: return i_ins(mips_pkg::OP_ANDI, 8, 2, b[15:0]);
            14: return i_ins(mips_pkg::OP_ORI, 8, 2, b[15:0]);
            15: return i_ins(mips_pkg::OP_XORI, 8, 2, b[15:0]);
            default: return i_ins(mips_pkg::OP_LUI, 0, 2, b[15:0]);
        endcase
    endfunction

    function automatic logic [31:0] alu_expect(int k, logic [31:0] a, logic [31:0] b);
        logic [31:0] se;
        se = {{16{b[15]}}, b[15:0]};
        case (k)
            0:  return a + b;
            1:  return a - b;
            2:  return a & b;
            3:  return a | b;
            4:  return a ^ b;
            5:  return {31'b0, $signed(a) < $signed(b)};
            6:  return {31'b0, a < b};
            7:  return b << b[4:0];
            8:  return b >> b[4:0];
            9:  return 32'($signed(b) >>> b[4:0]);
            10: return a + se;
            11: return {31'b0, $signed(a) < $signed(se)};
            12: return {31'b0, a < se};
            13: return a & {16'h0, b[15:0]};
            14: return a | {16'h0, b[15:0]};
            15: return a ^ {16'h0, b[15:0]};
            default: return {b[15:0], 16'h0};
        endcase
    endfunction

    // Load the program, pulse reset, wait for halt and check v0
    task automatic run_program(input logic [31:0] expected);
        budget += 20 * prog.size() + 20;
        for (int i = 0; i < 1024; i++) begin
            mem_model.mem[i] = 32'h5A5A_0000 ^ (i * 32'h0001_0003);
        end
        foreach (prog[i]) begin
            mem_model.mem[i] = prog[i];
        end
        fetch_addr  = mips_pkg::RESET_VECTOR;
        store_count = 0;
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        while (active) @(negedge clk);
        assert (register_v0 === expected) else begin
            value_errors++;
            $display("Fail %s expected %h actual %h", test_name, expected, register_v0);
        end
    endtask

    task automatic alu_tests();
        for (int k = 0; k < 17; k++) begin
            prog.delete();
            load_word(8, opa[k]);
            load_word(9, opb[k]);
            prog.push_back(alu_instr(k, opb[k]));
            prog.push_back(r_ins(mips_pkg::FN_JR, 0, 0, 0, 0));
            test_name = alu_names[k];
            run_program(alu_expect(k, opa[k], opb[k]));
        end
        // A write to register 0 must not stick
        prog.delete();
        load_word(8, opa[0]);
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 8, 0, opb[0][15:0]));
        prog.push_back(i_ins(mips_pkg::OP_ORI, 0, 2, 16'h0001));
        prog.push_back(r_ins(mips_pkg::FN_ADDU, 0, 0, 2, 0));
        prog.push_back(r_ins(mips_pkg::FN_JR, 0, 0, 0, 0));
        test_name = "zero_reg";
        run_program(32'h0);
    endtask

    task automatic memory_test();
        prog.delete();
        load_word(8, mips_pkg::RESET_VECTOR + 32'h200);
        load_word(9, mem_val);
        prog.push_back(i_ins(mips_pkg::OP_SW, 8, 9, 16'd4));
        prog.push_back(i_ins(mips_pkg::OP_LW, 8, 2, 16'd4));
        prog.push_back(r_ins(mips_pkg::FN_JR, 0, 0, 0, 0));
        store_addr = mips_pkg::RESET_VECTOR + 32'h204;
        store_data = mem_val;
        test_name  = "sw_lw";
        run_program(mem_val);
        assert (store_count == 1) else begin
            protocol_errors++;
            $display("Store did not produce exactly one write transfer");
        end
    endtask

    // Skipped instructions add bits that must never show up in v0
    task automatic control_test();
        logic [31:0] j_addr;
        j_addr = mips_pkg::RESET_VECTOR + 32'd52;
        prog.delete();
        prog.push_back(i_ins(mips_pkg::OP_ORI, 0, 8, 16'd5));
        prog.push_back(i_ins(mips_pkg::OP_ORI, 0, 9, 16'd5));
        prog.push_back(i_ins(mips_pkg::OP_BEQ, 8, 9, 16'd1));
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 2, 2, 16'h0100));
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 2, 2, 16'h0001));
        prog.push_back(i_ins(mips_pkg::OP_BNE, 8, 9, 16'd1));
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 2, 2, 16'h0002));
        prog.push_back(i_ins(mips_pkg::OP_BNE, 8, 0, 16'd1));
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 2, 2, 16'h0200));
        prog.push_back(i_ins(mips_pkg::OP_BEQ, 8, 0, 16'd1));
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 2, 2, 16'h0004));
        prog.push_back({6'd2, j_addr[27:2]});
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 2, 2, 16'h0400));
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 2, 2, 16'h0008));
        prog.push_back(r_ins(mips_pkg::FN_JR, 0, 0, 0, 0));
        test_name = "branch_jump";
        run_program(32'd15);
    endtask

    // Inputs change 1 time unit after the rising edge
    always @(posedge clk) begin
        #1 waitrequest = wait_en ? next_bit() : 1'b0;
    end

    always @(posedge clk) begin
        cycles++;
        reset_q <= reset;
        if (cycles > budget) begin
            $display("Timeout, the core did not halt within %0d cycles", budget);
            $display("Verification failed");
            $finish;
        end
    end

    // Protocol checks on the falling edge with all outputs settled
    always @(negedge clk) begin
        if (reset && reset_q) begin
            assert (!read && !write && active) else begin
                protocol_errors++;
                $display("Bus strobe raised or active low during reset");
            end
        end
        if (!reset && active === 1'b0) begin
            assert (!read && !write) else begin
                protocol_errors++;
                $display("Bus strobe raised after the core halted");
            end
        end
        if (!reset) begin
            assert (!(read && write)) else begin
                protocol_errors++;
                $display("Read and write raised together");
            end
        end
        if (!reset && (read || write)) begin
            assert (byteenable == 4'hF) else begin
                protocol_errors++;
                $display("Byteenable not all ones during a transfer");
            end
        end
        if (!reset && stalled) begin
            assert (address == prev_addr && read == prev_read && write == prev_write
                    && writedata == prev_wdata) else begin
                protocol_errors++;
                $display("Bus outputs changed while waitrequest was high");
            end
        end
        if (!reset && check_fetch && read && !waitrequest) begin
            assert (address == fetch_addr) else begin
                value_errors++;
                $display("Fail %s expected %h actual %h", test_name, fetch_addr, address);
            end
            fetch_addr = fetch_addr + 32'd4;
        end
        if (!reset && write && !waitrequest) begin
            store_count++;
            assert (address == store_addr && writedata == store_data) else begin
                value_errors++;
                $display("Fail %s expected %h actual %h", test_name,
                         {store_addr, store_data}, {address, writedata});
            end
        end
        stalled    = !reset && (read || write) && waitrequest;
        prev_addr  = address;
        prev_read  = read;
        prev_write = write;
        prev_wdata = writedata;
    end

    initial begin
        reset           = 1'b1;
        waitrequest     = 1'b0;
        wait_en         = 1'b0;
        check_fetch     = 1'b0;
        stalled         = 1'b0;
        lfsr            = 32'd74965;
        value_errors    = 0;
        protocol_errors = 0;
        cycles          = 0;
        budget          = 200;
        for (int k = 0; k < 17; k++) begin
            opa[k] = rand_word();
            opb[k] = rand_word();
        end
        mem_val = rand_word();

        // Straight-line code where fetch addresses step by 4
        prog.delete();
        prog.push_back(i_ins(mips_pkg::OP_ORI, 0, 2, 16'h0011));
        prog.push_back(i_ins(mips_pkg::OP_ADDIU, 2, 2, 16'h0022));
        prog.push_back(i_ins(mips_pkg::OP_XORI, 2, 2, 16'h000F));
        prog.push_back(r_ins(mips_pkg::FN_JR, 0, 0, 0, 0));
        test_name   = "fetch";
        check_fetch = 1'b1;
        run_program((32'h11 + 32'h22) ^ 32'h0F);
        check_fetch = 1'b0;

        // Second pass repeats everything with random wait states
        for (int pass = 0; pass < 2; pass++) begin
            wait_en = (pass == 1);
            alu_tests();
            memory_test();
            control_test();
        end

        $display("Errors: value %0d, protocol %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tests/avalon_mem.sv */
/*
 * Avalon word memory model
 * 1024 words indexed by address bits 11..2, waitrequest supplied by the testbench LFSR
 */
module avalon_mem (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    input  logic        waitrequest,
    output logic [31:0] readdata
);

    logic [31:0] mem [1024];

    // Read data is valid in the completing cycle
    assign readdata = read ? mem[address[11:2]] : 32'h0;

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[address[11:2]][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* tests/clock_gen.sv */
/*
 * Testbench clock source
 * Free-running clock with a configurable period
 */
module clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* rtl/mips_cpu_bus.sv */
/*
 * MIPS CPU top level
 * Multicycle core with an Avalon memory-mapped master port
 */
module mips_cpu_bus (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          active,
    output logic [mips_pkg::WORD_W-1:0]   register_v0,

    // Avalon master
    output logic [mips_pkg::WORD_W-1:0]   address,
    output logic                          write,
    output logic                          read,
    input  logic                          waitrequest,
    output logic [mips_pkg::WORD_W-1:0]   writedata,
    output logic [3:0]                    byteenable,
    input  logic [mips_pkg::WORD_W-1:0]   readdata
);

    mips_pkg::instr_t                    instr;
    mips_pkg::exec_t                     exec;
    logic [mips_pkg::WORD_W-1:0]         pc;
    logic [mips_pkg::REG_ADDR_W-1:0]     rs_addr;
    logic [mips_pkg::REG_ADDR_W-1:0]     rt_addr;
    logic [mips_pkg::WORD_W-1:0]         rs_data;
    logic [mips_pkg::WORD_W-1:0]         rt_data;
    logic                                wr_en;
    logic [mips_pkg::REG_ADDR_W-1:0]     wr_reg;
    logic [mips_pkg::WORD_W-1:0]         wr_data;

    mips_control u_control (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .exec        (exec),
        .instr       (instr),
        .pc          (pc),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .wr_en       (wr_en),
        .wr_reg      (wr_reg),
        .wr_data     (wr_data)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_en   (wr_en),
        .wr_reg  (wr_reg),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0_data (register_v0)
    );

    mips_execute u_execute (
        .instr   (instr),
        .pc      (pc),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .exec    (exec)
    );

endmodule

/* rtl/mips_control.sv */
/*
 * MIPS control unit
 * Fetch, execute, memory and halt sequencing with PC, instruction register and bus drive
 */
module mips_control (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              waitrequest,
    input  logic [mips_pkg::WORD_W-1:0]       readdata,
    input  mips_pkg::exec_t                   exec,
    output mips_pkg::instr_t                  instr,
    output logic [mips_pkg::WORD_W-1:0]       pc,
    output logic                              active,
    output logic [mips_pkg::WORD_W-1:0]       address,
    output logic                              read,
    output logic                              write,
    output logic [mips_pkg::WORD_W-1:0]       writedata,
    output logic [3:0]                        byteenable,
    output logic                              wr_en,
    output logic [mips_pkg::REG_ADDR_W-1:0]   wr_reg,
    output logic [mips_pkg::WORD_W-1:0]       wr_data
);

    mips_pkg::state_e state;
    logic             fetch_done;
    logic             load_done;

    // A transfer completes when the strobe is up and the slave does not stall
    assign fetch_done = (state == mips_pkg::FETCH) && read && !waitrequest;
    assign load_done  = (state == mips_pkg::MEM) && read && !waitrequest;

    // Only full-word transfers
    assign byteenable = 4'b1111;

    // ALU results go back in EXEC, load data when the MEM read completes
    assign wr_reg  = exec.wb_reg;
    assign wr_en   = ((state == mips_pkg::EXEC) && exec.wb_en) || load_done;
    assign wr_data = load_done ? readdata : exec.wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= mips_pkg::FETCH;
            pc      <= mips_pkg::RESET_VECTOR;
            address <= mips_pkg::RESET_VECTOR;
            read    <= 1'b0;
            write   <= 1'b0;
            active  <= 1'b1;
        end else begin
            case (state)
                mips_pkg::FETCH: begin
                    // First fetch after reset raises read here,
                    // later fetches are issued from EXEC or MEM
                    if (!read) begin
                        read <= 1'b1;
                    end else if (!waitrequest) begin
                        read  <= 1'b0;
                        state <= mips_pkg::EXEC;
                    end
                end

                mips_pkg::EXEC: begin
                    pc <= exec.next_pc;
                    if (exec.mem_op != mips_pkg::MEM_NONE) begin
                        address <= exec.mem_addr;
                        read    <= (exec.mem_op == mips_pkg::MEM_LOAD);
                        write   <= (exec.mem_op == mips_pkg::MEM_STORE);
                        state   <= mips_pkg::MEM;
                    end else if (exec.next_pc == '0) begin
                        // Jump to address zero ends execution
                        active <= 1'b0;
                        state  <= mips_pkg::HALT;
                    end else begin
                        address <= exec.next_pc;
                        read    <= 1'b1;
                        state   <= mips_pkg::FETCH;
                    end
                end

                mips_pkg::MEM: begin
                    // Issue the next fetch straight from the completing cycle
                    if (!waitrequest) begin
                        address <= pc;
                        read    <= 1'b1;
                        write   <= 1'b0;
                        state   <= mips_pkg::FETCH;
                    end
                end

                mips_pkg::HALT: begin
                    state <= mips_pkg::HALT;
                end

                default: begin
                    state <= mips_pkg::HALT;
                end
            endcase
        end
    end

    // Instruction register and store data
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= mips_pkg::instr_t'(readdata);
        end
        if (state == mips_pkg::EXEC) begin
            writedata <= exec.store_data;
        end
    end

endmodule

/* rtl/mips_execute.sv */
/*
 * MIPS execute unit
 * Decodes the instruction and forms the ALU result, next PC and memory request
 */
module mips_execute (
    input  mips_pkg::instr_t                  instr,
    input  logic [mips_pkg::WORD_W-1:0]       pc,
    input  logic [mips_pkg::WORD_W-1:0]       rs_data,
    input  logic [mips_pkg::WORD_W-1:0]       rt_data,
    output logic [mips_pkg::REG_ADDR_W-1:0]   rs_addr,
    output logic [mips_pkg::REG_ADDR_W-1:0]   rt_addr,
    output mips_pkg::exec_t                   exec
);

    logic [15:0]                   imm;
    logic [25:0]                   target;
    logic [mips_pkg::WORD_W-1:0]   imm_sext;
    logic [mips_pkg::WORD_W-1:0]   imm_zext;
    logic [mips_pkg::WORD_W-1:0]   pc_plus4;
    logic [mips_pkg::WORD_W-1:0]   branch_target;

    assign rs_addr = instr.rs;
    assign rt_addr = instr.rt;

    // I and J fields overlay the low bits of the R format
    assign imm           = instr[15:0];
    assign target        = instr[25:0];
    assign imm_sext      = {{16{imm[15]}}, imm};
    assign imm_zext      = {16'h0000, imm};
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};

    always_comb begin
        exec.wb_en      = 1'b0;
        exec.wb_reg     = instr.rt;
        exec.wb_data    = '0;
        exec.next_pc    = pc_plus4;
        exec.mem_op     = mips_pkg::MEM_NONE;
        exec.mem_addr   = rs_data + imm_sext;
        exec.store_data = rt_data;

        case (instr.opcode)
            mips_pkg::OP_SPECIAL: begin
                exec.wb_reg = instr.rd;
                exec.wb_en  = 1'b1;
                case (instr.funct)
                    mips_pkg::FN_SLL:  exec.wb_data = rt_data << instr.shamt;
                    mips_pkg::FN_SRL:  exec.wb_data = rt_data >> instr.shamt;
                    mips_pkg::FN_SRA:  exec.wb_data = $signed(rt_data) >>> instr.shamt;
                    mips_pkg::FN_ADDU: exec.wb_data = rs_data + rt_data;
                    mips_pkg::FN_SUBU: exec.wb_data = rs_data - rt_data;
                    mips_pkg::FN_AND:  exec.wb_data = rs_data & rt_data;
                    mips_pkg::FN_OR:   exec.wb_data = rs_data | rt_data;
                    mips_pkg::FN_XOR:  exec.wb_data = rs_data ^ rt_data;
                    mips_pkg::FN_SLT: begin
                        exec.wb_data = {31'b0, $signed(rs_data) < $signed(rt_data)};
                    end
                    mips_pkg::FN_SLTU: begin
                        exec.wb_data = {31'b0, rs_data < rt_data};
                    end
                    mips_pkg::FN_JR: begin
                        exec.wb_en   = 1'b0;
                        exec.next_pc = rs_data;
                    end
                    // Unknown function codes fall through as a no-op
                    default: exec.wb_en = 1'b0;
                endcase
            end

            mips_pkg::OP_J: begin
                exec.next_pc = {pc_plus4[31:28], target, 2'b00};
            end

            mips_pkg::OP_BEQ: begin
                if (rs_data == rt_data) begin
                    exec.next_pc = branch_target;
                end
            end

            mips_pkg::OP_BNE: begin
                if (rs_data != rt_data) begin
                    exec.next_pc = branch_target;
                end
            end

            mips_pkg::OP_ADDIU: begin
                exec.wb_en   = 1'b1;
                exec.wb_data = rs_data + imm_sext;
            end

            mips_pkg::OP_SLTI: begin
                exec.wb_en   = 1'b1;
                exec.wb_data = {31'b0, $signed(rs_data) < $signed(imm_sext)};
            end

            // Immediate is sign extended, then compared unsigned
            mips_pkg::OP_SLTIU: begin
                exec.wb_en   = 1'b1;
                exec.wb_data = {31'b0, rs_data < imm_sext};
            end

            mips_pkg::OP_ANDI: begin
                exec.wb_en   = 1'b1;
                exec.wb_data = rs_data & imm_zext;
            end

            mips_pkg::OP_ORI: begin
                exec.wb_en   = 1'b1;
                exec.wb_data = rs_data | imm_zext;
            end

            mips_pkg::OP_XORI: begin
                exec.wb_en   = 1'b1;
                exec.wb_data = rs_data ^ imm_zext;
            end

            mips_pkg::OP_LUI: begin
                exec.wb_en   = 1'b1;
                exec.wb_data = {imm, 16'h0000};
            end

            // Load data is written back by control at the end of MEM
            mips_pkg::OP_LW: exec.mem_op = mips_pkg::MEM_LOAD;
            mips_pkg::OP_SW: exec.mem_op = mips_pkg::MEM_STORE;

            default: begin
                exec.wb_en = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/mips_regfile.sv */
/*
 * MIPS register file
 * 32 words, two combinational read ports, one write port, register 0 reads zero
 */
module mips_regfile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   rs_addr,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   rt_addr,
    input  logic                              wr_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   wr_reg,
    input  logic [mips_pkg::WORD_W-1:0]       wr_data,
    output logic [mips_pkg::WORD_W-1:0]       rs_data,
    output logic [mips_pkg::WORD_W-1:0]       rt_data,
    output logic [mips_pkg::WORD_W-1:0]       v0_data
);

    logic [mips_pkg::WORD_W-1:0] regs [mips_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_reg != '0)) begin
            // Register 0 is never written, so it stays at its reset value
            regs[wr_reg] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0_data = regs[mips_pkg::V0_INDEX];

endmodule

/* rtl/mips_pkg.sv */
/*
 * MIPS core package
 * ISA widths, reset vector, opcode and state encodings, instruction and execute-result types
 */
package mips_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int NUM_REGS   = 32;
    localparam int V0_INDEX   = 2;

    localparam logic [WORD_W-1:0] RESET_VECTOR = 32'hBFC0_0000;

    // Primary opcodes, bits 31..26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_e;

    // Function codes of SPECIAL, bits 5..0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_e;

    // R-format view with the I and J fields in its low bits
    typedef struct packed {
        opcode_e                opcode;
        logic [REG_ADDR_W-1:0]  rs;
        logic [REG_ADDR_W-1:0]  rt;
        logic [REG_ADDR_W-1:0]  rd;
        logic [SHAMT_W-1:0]     shamt;
        funct_e                 funct;
    } instr_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef struct packed {
        logic                   wb_en;
        logic [REG_ADDR_W-1:0]  wb_reg;
        logic [WORD_W-1:0]      wb_data;
        logic [WORD_W-1:0]      next_pc;
        mem_op_e                mem_op;
        logic [WORD_W-1:0]      mem_addr;
        logic [WORD_W-1:0]      store_data;
    } exec_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } state_e;

endpackage
